// ==== Bender.yml ====
package:
  name: rv_ctrl

sources:
  - rv_ctrl_pkg.sv
  - sync_fifo.sv
  - apb_inst_port.sv
  - inst_decoder.sv
  - decode_unit.sv
  - rv_ctrl_top.sv
  - target: test
    files:
      - tb_rv_ctrl_top.sv

// ==== apb_inst_port.sv ====
module apb_inst_port import rv_ctrl_pkg::*; (
    // APB slave, zero wait states
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pslverr,

    // Instruction FIFO write side
    input  logic              inst_full,
    input  logic [CNT_W-1:0]  inst_count,
    output logic              inst_push,
    output logic [INST_W-1:0] inst_data,

    // Result FIFO read side
    input  logic              result_empty,
    input  logic [CTRL_W-1:0] result_data,
    input  logic [CNT_W-1:0]  result_count,
    output logic              result_pop
);

    logic access;
    logic wr_inst;
    logic rd_result;
    logic rd_status;

    // ----------------------------------------
    // Access decode
    // ----------------------------------------
    // Transfer completes in the access phase
    assign access = psel & penable;

    assign wr_inst   = access & pwrite & (paddr == REG_INST);
    assign rd_result = access & ~pwrite & (paddr == REG_RESULT);
    assign rd_status = access & ~pwrite & (paddr == REG_STATUS);

    // FIFO strobes only fire when the FIFO can take them
    assign inst_push  = wr_inst & ~inst_full;
    assign result_pop = rd_result & ~result_empty;

    assign inst_data = pwdata;

    // ----------------------------------------
    // Read data and error response
    // ----------------------------------------
    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (wr_inst) begin
                // Word dropped when the instruction FIFO is full
                pslverr = inst_full;
            end else if (rd_result) begin
                if (result_empty) begin
                    pslverr = 1'b1;
                end else begin
                    prdata = {{(APB_DW - CTRL_W){1'b0}}, result_data};
                end
            end else if (rd_status) begin
                prdata[STAT_INST_LSB +: CNT_W]   = inst_count;
                prdata[STAT_RESULT_LSB +: CNT_W] = result_count;
            end else begin
                // Unmapped address or wrong direction
                pslverr = 1'b1;
            end
        end
    end

endmodule

// ==== decode_unit.sv ====
module decode_unit import rv_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    // Instruction FIFO read side
    input  logic              inst_empty,
    input  logic [INST_W-1:0] inst_data,
    output logic              inst_pop,

    // Result FIFO write side
    input  logic              result_full,
    output logic              result_push,
    output logic [CTRL_W-1:0] result_data
);

    logic [CTRL_W-1:0] dec_ctrl;
    logic [CTRL_W-1:0] stage_ctrl;
    logic              stage_valid;

    inst_decoder i_inst_decoder (
        .inst (inst_data),
        .ctrl (dec_ctrl)
    );

    // ----------------------------------------
    // Handshakes
    // ----------------------------------------
    // Stage drains whenever the result FIFO has room
    assign result_push = stage_valid & ~result_full;

    // Refill when empty or draining this cycle
    assign inst_pop = ~inst_empty & (~stage_valid | ~result_full);

    assign result_data = stage_ctrl;

    // Payload register
    always_ff @(posedge clk) begin
        if (inst_pop) begin
            stage_ctrl <= dec_ctrl;
        end
    end

    // Valid bit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else if (inst_pop) begin
            stage_valid <= 1'b1;
        end else if (result_push) begin
            stage_valid <= 1'b0;
        end
    end

endmodule

// ==== inst_decoder.sv ====
module inst_decoder import rv_ctrl_pkg::*; (
    input  logic [INST_W-1:0] inst,
    output logic [CTRL_W-1:0] ctrl
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    alu_op_e     alu_op;
    imm_sel_e    imm_sel;
    rs1_src_e    rs1_src;
    logic        rd_wen;
    logic        mem_wen;
    logic        mem_ren;
    logic        jump;
    logic        branch;
    logic        rs2_sel;
    logic        inv;
    logic        comp_unsigned;

    // Instruction fields
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ----------------------------------------
    // Single-bit flags
    // ----------------------------------------
    // Stores and branches have no destination register
    assign rd_wen  = !(opcode == OP_STORE || opcode == OP_BRANCH);
    assign mem_wen = (opcode == OP_STORE);
    assign mem_ren = (opcode == OP_LOAD);
    assign jump    = (opcode == OP_JALR || opcode == OP_JAL);
    assign branch  = (opcode == OP_BRANCH);
    assign rs2_sel = (opcode == OP_REG || opcode == OP_BRANCH);

    // BEQ, BGE and BGEU take the inverted compare result
    assign inv = (opcode == OP_BRANCH)
               && (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);

    assign comp_unsigned = ((opcode == OP_BRANCH) && (funct3 == 3'b110 || funct3 == 3'b111))
                         || ((opcode == OP_IMM) && (funct3 == 3'b011))
                         || ((opcode == OP_REG) && (funct3 == 3'b011));

    // ----------------------------------------
    // Immediate format and operand 1 source
    // ----------------------------------------
    always_comb begin
        if (opcode == OP_LUI || opcode == OP_AUIPC) begin
            imm_sel = IMM_U20;
        end else if (opcode == OP_JAL) begin
            imm_sel = IMM_J20;
        end else if (opcode == OP_IMM && (funct3 == 3'b001 || funct3 == 3'b101)) begin
            imm_sel = IMM_SHAMT5;
        end else begin
            imm_sel = IMM_I12;
        end
    end

    always_comb begin
        if (opcode == OP_LUI) begin
            rs1_src = RS1_ZERO;
        end else if (opcode == OP_JAL || opcode == OP_AUIPC) begin
            rs1_src = RS1_PC;
        end else begin
            rs1_src = RS1_REG;
        end
    end

    // ----------------------------------------
    // ALU operation
    // ----------------------------------------
    always_comb begin
        alu_op = ALU_ADD;
        case (opcode)
            OP_IMM, OP_REG: begin
                case (funct3)
                    // SUB only exists in the register form
                    3'b000: begin
                        if (opcode == OP_REG && funct7 != 7'b0000000) begin
                            alu_op = ALU_SUB;
                        end else begin
                            alu_op = ALU_ADD;
                        end
                    end
                    3'b001:         alu_op = ALU_SLL;
                    3'b010, 3'b011: alu_op = ALU_CMP;
                    3'b100:         alu_op = ALU_XOR;
                    3'b101: begin
                        if (funct7 == 7'b0000000) begin
                            alu_op = ALU_SRL;
                        end else begin
                            alu_op = ALU_SRA;
                        end
                    end
                    3'b110:         alu_op = ALU_OR;
                    default:        alu_op = ALU_AND;
                endcase
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000, 3'b001:                 alu_op = ALU_EQ;
                    3'b100, 3'b101, 3'b110, 3'b111: alu_op = ALU_CMP;
                    default:                        alu_op = ALU_ADD;
                endcase
            end
            // Loads, stores, LUI, AUIPC and jumps all add
            default: alu_op = ALU_ADD;
        endcase
    end

    // Pack into the control word
    always_comb begin
        ctrl                              = '0;
        ctrl[CTRL_ALU_MSB:CTRL_ALU_LSB]   = alu_op;
        ctrl[CTRL_IMM_MSB:CTRL_IMM_LSB]   = imm_sel;
        ctrl[CTRL_RS1_MSB:CTRL_RS1_LSB]   = rs1_src;
        ctrl[CTRL_RS2_SEL]                = rs2_sel;
        ctrl[CTRL_COMP_UNS]               = comp_unsigned;
        ctrl[CTRL_INV]                    = inv;
        ctrl[CTRL_BRANCH]                 = branch;
        ctrl[CTRL_JUMP]                   = jump;
        ctrl[CTRL_MEM_REN]                = mem_ren;
        ctrl[CTRL_MEM_WEN]                = mem_wen;
        ctrl[CTRL_RD_WEN]                 = rd_wen;
    end

endmodule

// ==== rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int INST_W = 32;
    localparam int CTRL_W = 16;

    // APB side
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // FIFO geometry, count reaches FIFO_DEPTH so it needs one extra bit
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = 3;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------
    localparam logic [APB_AW-1:0] REG_INST   = 4'h0;
    localparam logic [APB_AW-1:0] REG_RESULT = 4'h4;
    localparam logic [APB_AW-1:0] REG_STATUS = 4'h8;

    // Status register fields
    localparam int STAT_INST_LSB   = 0;
    localparam int STAT_RESULT_LSB = 4;

    // ----------------------------------------
    // Control word layout
    // ----------------------------------------
    localparam int CTRL_ALU_LSB  = 0;
    localparam int CTRL_ALU_MSB  = 3;
    localparam int CTRL_IMM_LSB  = 4;
    localparam int CTRL_IMM_MSB  = 5;
    localparam int CTRL_RS1_LSB  = 6;
    localparam int CTRL_RS1_MSB  = 7;
    localparam int CTRL_RS2_SEL  = 8;
    localparam int CTRL_COMP_UNS = 9;
    localparam int CTRL_INV      = 10;
    localparam int CTRL_BRANCH   = 11;
    localparam int CTRL_JUMP     = 12;
    localparam int CTRL_MEM_REN  = 13;
    localparam int CTRL_MEM_WEN  = 14;
    localparam int CTRL_RD_WEN   = 15;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_JALR   = 7'b1100111,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_CMP = 4'd8,
        ALU_EQ  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I12    = 2'd0,
        IMM_U20    = 2'd1,
        IMM_J20    = 2'd2,
        IMM_SHAMT5 = 2'd3
    } imm_sel_e;

    // Operand 1 source, ZERO is used by LUI
    typedef enum logic [1:0] {
        RS1_REG  = 2'd0,
        RS1_PC   = 2'd1,
        RS1_ZERO = 2'd2
    } rs1_src_e;

endpackage

// ==== rv_ctrl_top.sv ====
module rv_ctrl_top import rv_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pslverr
);

    // Instruction FIFO
    logic              inst_push;
    logic [INST_W-1:0] inst_wdata;
    logic              inst_pop;
    logic [INST_W-1:0] inst_rdata;
    logic              inst_full;
    logic              inst_empty;
    logic [CNT_W-1:0]  inst_count;

    // Result FIFO
    logic              result_push;
    logic [CTRL_W-1:0] result_wdata;
    logic              result_pop;
    logic [CTRL_W-1:0] result_rdata;
    logic              result_full;
    logic              result_empty;
    logic [CNT_W-1:0]  result_count;

    apb_inst_port i_apb_inst_port (
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .inst_full    (inst_full),
        .inst_count   (inst_count),
        .inst_push    (inst_push),
        .inst_data    (inst_wdata),
        .result_empty (result_empty),
        .result_data  (result_rdata),
        .result_count (result_count),
        .result_pop   (result_pop)
    );

    sync_fifo #(
        .WIDTH (INST_W)
    ) i_inst_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (inst_push),
        .push_data (inst_wdata),
        .pop       (inst_pop),
        .pop_data  (inst_rdata),
        .full      (inst_full),
        .empty     (inst_empty),
        .count     (inst_count)
    );

    decode_unit i_decode_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_empty  (inst_empty),
        .inst_data   (inst_rdata),
        .inst_pop    (inst_pop),
        .result_full (result_full),
        .result_push (result_push),
        .result_data (result_wdata)
    );

    sync_fifo #(
        .WIDTH (CTRL_W)
    ) i_result_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (result_push),
        .push_data (result_wdata),
        .pop       (result_pop),
        .pop_data  (result_rdata),
        .full      (result_full),
        .empty     (result_empty),
        .count     (result_count)
    );

endmodule

// ==== sync_fifo.sv ====
module sync_fifo import rv_ctrl_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty,
    output logic [CNT_W-1:0] count
);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Guard against strobes that break the handshake
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign pop_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== tb_rv_ctrl_top.sv ====
module tb_rv_ctrl_top import rv_ctrl_pkg::*; ();

    localparam int CLK_HALF   = 2;
    localparam int DRIVE_DLY  = 1;
    localparam int RST_CYCLES = 16;
    localparam int WAIT_LIMIT = 50;
    localparam int SEED       = 3278;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pslverr;

    int checks;
    int mismatches;
    int timeouts;
    int cycle_cnt;

    rv_ctrl_top i_rv_ctrl_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Free-running cycle counter for the wait loops
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [CTRL_W-1:0] ref_decode(input logic [31:0] inst);
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [3:0] alu;
        logic [1:0] imm;
        logic [1:0] rs1;
        logic       rd_wen;
        logic       mem_wen;
        logic       mem_ren;
        logic       jump;
        logic       branch;
        logic       rs2_sel;
        logic       inv;
        logic       cu;
        op      = inst[6:0];
        f3      = inst[14:12];
        f7      = inst[31:25];
        rd_wen  = (op != OP_STORE) && (op != OP_BRANCH);
        mem_wen = (op == OP_STORE);
        mem_ren = (op == OP_LOAD);
        jump    = (op == OP_JAL) || (op == OP_JALR);
        branch  = (op == OP_BRANCH);
        rs2_sel = (op == OP_BRANCH) || (op == OP_REG);
        inv     = branch && (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7);
        cu      = (branch && f3[2:1] == 2'b11) || ((op == OP_IMM || op == OP_REG) && f3 == 3'd3);
        if (op == OP_LUI || op == OP_AUIPC) begin
            imm = IMM_U20;
        end else if (op == OP_JAL) begin
            imm = IMM_J20;
        end else if (op == OP_IMM && (f3 == 3'd1 || f3 == 3'd5)) begin
            imm = IMM_SHAMT5;
        end else begin
            imm = IMM_I12;
        end
        rs1 = RS1_REG;
        if (op == OP_LUI) begin
            rs1 = RS1_ZERO;
        end else if (op == OP_JAL || op == OP_AUIPC) begin
            rs1 = RS1_PC;
        end
        alu = ALU_ADD;
        if (op == OP_IMM || op == OP_REG) begin
            case (f3)
                3'd0: alu = (op == OP_REG && f7 != 7'd0) ? ALU_SUB : ALU_ADD;
                3'd1: alu = ALU_SLL;
                3'd2: alu = ALU_CMP;
                3'd3: alu = ALU_CMP;
                3'd4: alu = ALU_XOR;
                3'd5: alu = (f7 == 7'd0) ? ALU_SRL : ALU_SRA;
                3'd6: alu = ALU_OR;
                3'd7: alu = ALU_AND;
            endcase
        end else if (branch) begin
            if (f3 <= 3'd1) begin
                alu = ALU_EQ;
            end else if (f3 >= 3'd4) begin
                alu = ALU_CMP;
            end
        end
        return {rd_wen, mem_wen, mem_ren, jump, branch, inv, cu, rs2_sel, rs1, imm, alu};
    endfunction

    // Random register fields around fixed opcode and function bits
    function automatic logic [31:0] make_inst(input logic [6:0] op, input logic [2:0] f3,
                                              input logic [6:0] f7);
        logic [31:0] r;
        r = $urandom();
        return {f7, r[4:0], r[9:5], f3, r[14:10], op};
    endfunction

    function automatic logic [6:0] opcode_by_index(input int idx);
        case (idx)
            0:       return OP_LOAD;
            1:       return OP_IMM;
            2:       return OP_JALR;
            3:       return OP_STORE;
            4:       return OP_BRANCH;
            5:       return OP_LUI;
            6:       return OP_AUIPC;
            7:       return OP_JAL;
            default: return OP_REG;
        endcase
    endfunction

    // ----------------------------------------
    // APB driver and checks
    // ----------------------------------------
    task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        // Outputs settle well before the completing edge
        #DRIVE_DLY;
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic wait_for_result();
        int          start;
        logic [31:0] status;
        logic        err;
        logic        seen;
        start = cycle_cnt;
        seen  = 1'b0;
        while (!seen && (cycle_cnt - start) < WAIT_LIMIT) begin
            apb_read(REG_STATUS, status, err);
            seen = (status[6:4] != 3'd0);
        end
        assert (seen) else begin
            $display("Timeout: no result word became available within %0d cycles", WAIT_LIMIT);
            timeouts++;
        end
    endtask

    task automatic decode_and_check(input logic [31:0] inst);
        logic [31:0] rdata;
        logic        err;
        apb_write(REG_INST, inst, err);
        check_value("pslverr", 32'd0, err);
        wait_for_result();
        apb_read(REG_RESULT, rdata, err);
        check_value("pslverr", 32'd0, err);
        check_value("prdata", {16'd0, ref_decode(inst)}, rdata);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0] expected_q [$];
        logic [31:0] inst;
        logic [31:0] rdata;
        logic        err;
        void'($urandom(SEED));
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        // Reset state
        apb_read(REG_STATUS, rdata, err);
        check_value("prdata", 32'd0, rdata);
        check_value("pslverr", 32'd0, err);
        apb_read(REG_RESULT, rdata, err);
        check_value("prdata", 32'd0, rdata);
        check_value("pslverr", 32'd1, err);

        // One of each opcode
        for (int i = 0; i < 9; i++) begin
            decode_and_check(make_inst(opcode_by_index(i), 3'($urandom()), 7'($urandom())));
        end

        // Arithmetic forms with both funct7 variants
        for (int f = 0; f < 8; f++) begin
            decode_and_check(make_inst(OP_IMM, 3'(f), 7'b0000000));
            decode_and_check(make_inst(OP_IMM, 3'(f), 7'b0100000));
            decode_and_check(make_inst(OP_REG, 3'(f), 7'b0000000));
            decode_and_check(make_inst(OP_REG, 3'(f), 7'b0100000));
        end

        // Branches
        for (int f = 0; f < 8; f++) begin
            decode_and_check(make_inst(OP_BRANCH, 3'(f), 7'($urandom())));
        end

        // ----------------------------------------
        // Back-pressure by filling everything without reading
        // ----------------------------------------
        for (int i = 0; i < 2 * FIFO_DEPTH + 1; i++) begin
            inst = make_inst(opcode_by_index($urandom() % 9), 3'($urandom()), 7'($urandom()));
            // Every fourth word is fully random and mostly has an unknown opcode
            if (i % 4 == 3) begin
                inst = $urandom();
            end
            apb_write(REG_INST, inst, err);
            check_value("pslverr", 32'd0, err);
            expected_q.push_back(inst);
        end
        apb_write(REG_INST, $urandom(), err);
        check_value("pslverr", 32'd1, err);
        apb_read(REG_STATUS, rdata, err);
        check_value("prdata", {25'd0, 3'(FIFO_DEPTH), 1'b0, 3'(FIFO_DEPTH)}, rdata);
        check_value("pslverr", 32'd0, err);
        while (expected_q.size() > 0) begin
            inst = expected_q.pop_front();
            wait_for_result();
            apb_read(REG_RESULT, rdata, err);
            check_value("pslverr", 32'd0, err);
            check_value("prdata", {16'd0, ref_decode(inst)}, rdata);
        end
        apb_read(REG_STATUS, rdata, err);
        check_value("prdata", 32'd0, rdata);

        // Bad accesses
        apb_write(REG_STATUS, 32'h1234_5678, err);
        check_value("pslverr", 32'd1, err);
        apb_read(REG_INST, rdata, err);
        check_value("pslverr", 32'd1, err);
        check_value("prdata", 32'd0, rdata);
        apb_read(4'hC, rdata, err);
        check_value("pslverr", 32'd1, err);

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
        if (mismatches + timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rv_ctrl_pkg.sv
sync_fifo.sv
apb_inst_port.sv
inst_decoder.sv
decode_unit.sv
rv_ctrl_top.sv
tb_rv_ctrl_top.sv
